//--- list.f
src/rv32i_types.sv
src/fetch_stage.sv
src/regfile.sv
src/id_stage.sv
src/ex_stage.sv
src/wb_stage.sv
src/rv32i_core.sv
bench/tb_clock.sv
bench/core_properties.sv
bench/core_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := core_tb
FILELIST   := list.f
OBJ_DIR    := obj_dir
LOG        := sim.log
COMMON     := --timing --assert --timescale 1ns/1ps --top-module $(TOP)
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary -j 0 --Mdir $(OBJ_DIR) $(COMMON)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/core_tb.sv
module core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                 clk;
    logic                 reset;
    logic                 inst_valid;
    rv32i_types::word_t   inst;
    rv32i_types::commit_t commit;

    integer               seed;
    int unsigned          edge_count = 0;
    int unsigned          n_issued = 0;
    int unsigned          n_checked = 0;
    rv32i_types::word_t   model_regs [rv32i_types::nregs];
    rv32i_types::word_t   model_pc;
    rv32i_types::order_t  model_order;
    rv32i_types::commit_t expect_q [$];
    int unsigned          stamp_q [$];  // drive edge of each queued inst

    tb_clock clock0 (
        .o_clk (clk)
    );

    rv32i_core dut0 (
        .clk          (clk),
        .i_reset      (reset),
        .i_inst_valid (inst_valid),
        .i_inst       (inst),
        .o_commit     (commit)
    );

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // ======================================================================
    // error reporting and compare tasks
    // ======================================================================
    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_word(input string name, input rv32i_types::word_t exp,
                                input rv32i_types::word_t act);
        if (exp !== act) begin
            $display("[FAIL] time %0t: %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic match_reg_sel(input string name, input rv32i_types::reg_sel_t exp,
                                 input rv32i_types::reg_sel_t act);
        if (exp !== act) begin
            $display("[FAIL] time %0t: %s expected %0d actual %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_order(input string name, input rv32i_types::order_t exp,
                               input rv32i_types::order_t act);
        if (exp !== act) begin
            $display("[FAIL] time %0t: %s expected %0d actual %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic verify_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] time %0t: %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // ======================================================================
    // stimulus and architectural model
    // ======================================================================
    function automatic rv32i_types::word_t isa_result(input logic [2:0] f3, input logic alt,
                                                     input rv32i_types::word_t x,
                                                     input rv32i_types::word_t y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return {31'b0, $signed(x) < $signed(y)};
            3'b011:  return {31'b0, x < y};
            3'b100:  return x ^ y;
            3'b101:  return alt ? rv32i_types::word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    task automatic random_inst(output rv32i_types::word_t w);
        rv32i_types::word_t    r1;
        rv32i_types::word_t    r2;
        rv32i_types::reg_sel_t rd;
        rv32i_types::reg_sel_t rs1;
        rv32i_types::reg_sel_t rs2;
        logic [2:0]            f3;
        logic [6:0]            f7;
        logic [11:0]           imm;
        r1  = $random(seed);
        r2  = $random(seed);
        rd  = {2'b00, r1[7:5]};  // x0..x7 keeps dependencies dense
        rs1 = {2'b00, r1[10:8]};
        rs2 = {2'b00, r1[13:11]};
        f3  = r1[16:14];
        f7  = {1'b0, r1[17], 5'b00000};
        imm = r2[11:0];
        if (r1[4:0] < 5'd2) begin
            case (r1[19:18])  // load, store, branch, jal
                2'b00:   w = {r2[31:7], 7'b0000011};
                2'b01:   w = {r2[31:7], 7'b0100011};
                2'b10:   w = {r2[31:7], 7'b1100011};
                default: w = {r2[31:7], 7'b1101111};
            endcase
        end else if (r1[4:0] < 5'd5) begin
            w = {r2[31:12], rd, 7'b0110111};
        end else if (r1[4:0] < 5'd8) begin
            w = {r2[31:12], rd, 7'b0010111};
        end else if (r1[4:0] < 5'd20) begin
            if (f3 == 3'b001) begin
                imm[11:5] = 7'b0000000;
            end else if (f3 == 3'b101) begin
                imm[11:5] = f7;  // srli or srai
            end
            w = {imm, rs1, f3, rd, 7'b0010011};
        end else begin
            if (f3 != 3'b000 && f3 != 3'b101) begin
                f7 = 7'b0000000;
            end
            w = {f7, rs2, rs1, f3, rd, 7'b0110011};
        end
    endtask

    task automatic predict_commit(input rv32i_types::word_t w,
                                  output rv32i_types::commit_t c);
        rv32i_types::reg_sel_t rd;
        rv32i_types::word_t    a;
        rv32i_types::word_t    b;
        rv32i_types::word_t    imm_i;
        rv32i_types::word_t    imm_u;
        rv32i_types::word_t    res;
        logic                  writes;
        logic                  alt;
        rd     = w[11:7];
        a      = model_regs[w[19:15]];
        b      = model_regs[w[24:20]];
        imm_i  = {{20{w[31]}}, w[31:20]};
        imm_u  = {w[31:12], 12'h000};
        writes = 1'b1;
        res    = '0;
        case (w[6:0])
            7'b0110111: res = imm_u;
            7'b0010111: res = model_pc + imm_u;
            7'b0010011: begin
                alt = (w[14:12] == 3'b101) ? w[30] : 1'b0;  // no subi
                res = isa_result(w[14:12], alt, a, imm_i);
            end
            7'b0110011: res = isa_result(w[14:12], w[30], a, b);
            default:    writes = 1'b0;
        endcase
        c.valid = 1'b1;
        c.order = model_order;
        c.pc    = model_pc;
        c.inst  = w;
        c.rd_s  = rd;
        c.rd_v  = res;
        c.we    = writes;
        if (writes && rd != 5'd0) begin
            model_regs[rd] = res;
        end
        model_pc    = model_pc + 32'd4;
        model_order = model_order + 64'd1;
    endtask

    initial begin
        rv32i_types::word_t   w;
        rv32i_types::word_t   r;
        rv32i_types::commit_t c;
        int unsigned          wait_cycles;
        seed        = 73906;
        reset       = 1'b1;
        inst_valid  = 1'b0;
        inst        = '0;
        model_pc    = '0;
        model_order = '0;
        for (int i = 0; i < rv32i_types::nregs; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        while (n_issued < 400) begin
            @(posedge clk);
            r = $random(seed);
            if (r[1:0] == 2'b00) begin  // idle, junk on the bus
                inst_valid <= 1'b0;
                inst       <= r;
            end else begin
                random_inst(w);
                predict_commit(w, c);
                inst_valid <= 1'b1;
                inst       <= w;
                expect_q.push_back(c);
                stamp_q.push_back(edge_count);
                n_issued++;
            end
        end
        @(posedge clk);
        inst_valid <= 1'b0;

        wait_cycles = 0;
        while (expect_q.size() != 0 && wait_cycles < 50) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (expect_q.size() != 0) begin
            $display("drain timed out with %0d commits still outstanding", expect_q.size());
            abort_run();
        end else if (dut0.props0.n_failed != 0) begin
            $display("a bound assertion on the core failed during the run");
            abort_run();
        end else begin
            $display("%0d commits checked", n_checked);
            $display("STATUS: PASS");
            $finish;
        end
    end

    // ======================================================================
    // commit monitor
    // ======================================================================
    always @(negedge clk) begin : monitor
        rv32i_types::commit_t exp;
        int unsigned          stamp;
        if (dut0.props0.n_failed != 0) begin
            $display("a bound assertion on the core failed before time %0t", $time);
            abort_run();
        end else if (!reset && commit.valid === 1'b1) begin
            if (expect_q.size() == 0) begin
                $display("commit at time %0t with no instruction outstanding", $time);
                abort_run();
            end else begin
                exp   = expect_q.pop_front();
                stamp = stamp_q.pop_front();
                check_order("o_commit.order", exp.order, commit.order);
                compare_word("o_commit.pc", exp.pc, commit.pc);
                compare_word("o_commit.inst", exp.inst, commit.inst);
                match_reg_sel("o_commit.rd_s", exp.rd_s, commit.rd_s);
                verify_flag("o_commit.we", exp.we, commit.we);
                if (exp.we) begin
                    compare_word("o_commit.rd_v", exp.rd_v, commit.rd_v);
                end
                // three edges after the drive edge the count reads stamp + 4
                if (edge_count - stamp != 4) begin
                    $display("commit %0d came %0d edges after its drive edge instead of 3",
                             exp.order, edge_count - stamp - 1);
                    abort_run();
                end
                n_checked++;
            end
        end
    end

endmodule

//--- bench/core_properties.sv
module core_properties (
    input logic                          clk,
    input logic                          i_reset,
    input rv32i_types::commit_t          i_commit,
    input rv32i_types::id_ex_stage_reg_t i_id_ex
);

    timeunit 1ns;
    timeprecision 100ps;

    rv32i_types::order_t last_order;
    logic                seen_commit;
    int unsigned         n_failed = 0;  // failed assertions so far

    always_ff @(posedge clk) begin
        if (i_reset) begin
            seen_commit <= 1'b0;
            last_order  <= '0;
        end else if (i_commit.valid) begin
            seen_commit <= 1'b1;
            last_order  <= i_commit.order;
        end
    end

    // ======================================================================
    // commit port
    // ======================================================================
    commit_quiet_after_reset: assert property (
        @(posedge clk) $fell(i_reset) |-> !i_commit.valid
    ) else begin
        $error("commit valid high in the cycle after reset");
        n_failed = n_failed + 1;
    end

    order_steps_by_one: assert property (
        @(posedge clk) disable iff (i_reset)
        (i_commit.valid && seen_commit) |-> (i_commit.order == last_order + 64'd1)
    ) else begin
        $error("commit order did not step by one");
        n_failed = n_failed + 1;
    end

    // a commit to x0 must never show up in a later read
    x0_reads_zero_rs1: assert property (
        @(posedge clk) disable iff (i_reset)
        (i_id_ex.valid && i_id_ex.rs1_s == '0) |-> (i_id_ex.rs1_v == '0)
    ) else begin
        $error("decode read a nonzero value from x0 on rs1");
        n_failed = n_failed + 1;
    end

    x0_reads_zero_rs2: assert property (
        @(posedge clk) disable iff (i_reset)
        (i_id_ex.valid && i_id_ex.rs2_s == '0) |-> (i_id_ex.rs2_v == '0)
    ) else begin
        $error("decode read a nonzero value from x0 on rs2");
        n_failed = n_failed + 1;
    end

endmodule

bind rv32i_core core_properties props0 (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_commit (o_commit),
    .i_id_ex  (id_ex)
);

//--- bench/tb_clock.sv
module tb_clock (
    output logic o_clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever begin
            #50 o_clk = ~o_clk;  // 100 ns period
        end
    end

endmodule

//--- src/rv32i_core.sv
module rv32i_core (
    input  logic                 clk,
    input  logic                 i_reset,
    input  logic                 i_inst_valid,
    input  rv32i_types::word_t   i_inst,
    output rv32i_types::commit_t o_commit
);

    rv32i_types::if_id_stage_reg_t if_id;
    rv32i_types::id_ex_stage_reg_t id_ex;
    rv32i_types::ex_wb_stage_reg_t ex_wb;
    rv32i_types::regf_write_t      regf_write;  // regfile write and forward

    fetch_stage fetch0 (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .o_if_id      (if_id)
    );

    id_stage decode0 (
        .clk     (clk),
        .i_reset (i_reset),
        .i_if_id (if_id),
        .i_write (regf_write),
        .o_id_ex (id_ex)
    );

    ex_stage execute0 (
        .clk     (clk),
        .i_reset (i_reset),
        .i_id_ex (id_ex),
        .i_fwd   (regf_write),
        .o_ex_wb (ex_wb)
    );

    wb_stage writeback0 (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_ex_wb  (ex_wb),
        .o_write  (regf_write),
        .o_commit (o_commit)
    );

endmodule

//--- src/wb_stage.sv
module wb_stage (
    input  logic                          clk,
    input  logic                          i_reset,
    input  rv32i_types::ex_wb_stage_reg_t i_ex_wb,
    output rv32i_types::regf_write_t      o_write,
    output rv32i_types::commit_t          o_commit
);

    rv32i_types::ex_wb_stage_reg_t ex_wb;
    rv32i_types::word_t            rd_v;
    logic                          we;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            ex_wb.valid <= 1'b0;
        end else begin
            ex_wb <= i_ex_wb;
        end
    end

    always_comb begin
        case (ex_wb.wb_signal.regf_m_sel)
            rv32i_types::alu_out_wb: rd_v = ex_wb.alu_out;
            rv32i_types::br_en_wb:   rd_v = {{(rv32i_types::xlen-1){1'b0}}, ex_wb.br_en};
            rv32i_types::u_imm_wb:   rd_v = ex_wb.u_imm;
            default:                 rd_v = '0;
        endcase
    end

    assign we = ex_wb.valid && ex_wb.wb_signal.regf_we;

    always_comb begin
        o_write.we      = we;
        o_write.rd_s    = ex_wb.rd_s;
        o_write.rd_v    = rd_v;
        o_commit.valid  = ex_wb.valid;
        o_commit.order  = ex_wb.order;
        o_commit.pc     = ex_wb.pc;
        o_commit.inst   = ex_wb.inst;
        o_commit.rd_s   = ex_wb.rd_s;
        o_commit.rd_v   = rd_v;
        o_commit.we     = we;
    end

endmodule

//--- src/ex_stage.sv
module ex_stage (
    input  logic                          clk,
    input  logic                          i_reset,
    input  rv32i_types::id_ex_stage_reg_t i_id_ex,
    input  rv32i_types::regf_write_t      i_fwd,
    output rv32i_types::ex_wb_stage_reg_t o_ex_wb
);

    rv32i_types::id_ex_stage_reg_t id_ex;
    rv32i_types::word_t            rs1_v;
    rv32i_types::word_t            rs2_v;
    rv32i_types::word_t            alu_a;
    rv32i_types::word_t            alu_b;
    rv32i_types::word_t            cmp_b;
    rv32i_types::word_t            alu_out;
    logic [4:0]                    shamt;
    logic                          br_en;
    logic                          fwd_live;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex <= i_id_ex;
        end
    end

    // ===================================================================
    // forwarding from writeback
    // ===================================================================
    assign fwd_live = i_fwd.we && (i_fwd.rd_s != '0);
    assign rs1_v = (fwd_live && i_fwd.rd_s == id_ex.rs1_s) ? i_fwd.rd_v : id_ex.rs1_v;
    assign rs2_v = (fwd_live && i_fwd.rd_s == id_ex.rs2_s) ? i_fwd.rd_v : id_ex.rs2_v;

    always_comb begin
        case (id_ex.ex_signal.alu_m1_sel)
            rv32i_types::pc_out_alu_ex: alu_a = id_ex.pc;
            default:                    alu_a = rs1_v;
        endcase
        case (id_ex.ex_signal.alu_m2_sel)
            rv32i_types::u_imm_alu_ex: alu_b = id_ex.u_imm;
            rv32i_types::rs2_v_alu_ex: alu_b = rs2_v;
            default:                   alu_b = id_ex.i_imm;
        endcase
        cmp_b = (id_ex.ex_signal.cmp_m_sel == rv32i_types::rs2_v_cmp_ex) ? rs2_v : id_ex.i_imm;
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (id_ex.ex_signal.alu_ops)
            rv32i_types::sll_alu_op: alu_out = alu_a << shamt;
            rv32i_types::sra_alu_op: alu_out = rv32i_types::word_t'($signed(alu_a) >>> shamt);
            rv32i_types::sub_alu_op: alu_out = alu_a - alu_b;
            rv32i_types::xor_alu_op: alu_out = alu_a ^ alu_b;
            rv32i_types::srl_alu_op: alu_out = alu_a >> shamt;
            rv32i_types::or_alu_op:  alu_out = alu_a | alu_b;
            rv32i_types::and_alu_op: alu_out = alu_a & alu_b;
            default:                 alu_out = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (id_ex.ex_signal.cmp_ops)
            rv32i_types::blt_cmp_op:  br_en = $signed(rs1_v) < $signed(cmp_b);
            rv32i_types::bltu_cmp_op: br_en = rs1_v < cmp_b;
            default:                  br_en = 1'b0;
        endcase
    end

    always_comb begin
        o_ex_wb.valid     = id_ex.valid;
        o_ex_wb.inst      = id_ex.inst;
        o_ex_wb.pc        = id_ex.pc;
        o_ex_wb.order     = id_ex.order;
        o_ex_wb.rd_s      = id_ex.rd_s;
        o_ex_wb.alu_out   = alu_out;
        o_ex_wb.br_en     = br_en;
        o_ex_wb.u_imm     = id_ex.u_imm;  // lui bypasses the alu
        o_ex_wb.wb_signal = id_ex.wb_signal;
    end

endmodule

//--- src/id_stage.sv
module id_stage (
    input  logic                          clk,
    input  logic                          i_reset,
    input  rv32i_types::if_id_stage_reg_t i_if_id,
    input  rv32i_types::regf_write_t      i_write,
    output rv32i_types::id_ex_stage_reg_t o_id_ex
);

    rv32i_types::word_t       rs1_v;
    rv32i_types::word_t       rs2_v;
    rv32i_types::ex_signal_t  ex_signal;
    rv32i_types::mem_signal_t mem_signal;
    rv32i_types::wb_signal_t  wb_signal;

    regfile regfile0 (
        .clk     (clk),
        .i_reset (i_reset),
        .i_write (i_write),
        .i_rs1_s (i_if_id.rs1_s),
        .i_rs2_s (i_if_id.rs2_s),
        .o_rs1_v (rs1_v),
        .o_rs2_v (rs2_v)
    );

    // ===================================================================
    // control decode
    // ===================================================================
    always_comb begin
        ex_signal.alu_m1_sel = rv32i_types::alu_m1_sel_t'('x);
        ex_signal.alu_m2_sel = rv32i_types::alu_m2_sel_t'('x);
        ex_signal.alu_ops    = rv32i_types::alu_op_t'('x);
        ex_signal.cmp_m_sel  = rv32i_types::cmp_m_sel_t'('x);
        ex_signal.cmp_ops    = rv32i_types::cmp_op_t'('x);

        mem_signal.mem_read  = 1'b0;  // no loads or stores
        mem_signal.mem_write = 1'b0;
        mem_signal.load_ops  = 'x;
        mem_signal.store_ops = 'x;

        wb_signal.regf_m_sel = rv32i_types::regf_m_sel_t'('x);
        wb_signal.regf_we    = 1'b0;

        case (i_if_id.opcode)
            rv32i_types::lui_opcode: begin
                wb_signal.regf_m_sel = rv32i_types::u_imm_wb;
                wb_signal.regf_we    = 1'b1;
            end
            rv32i_types::auipc_opcode: begin
                ex_signal.alu_m1_sel = rv32i_types::pc_out_alu_ex;
                ex_signal.alu_m2_sel = rv32i_types::u_imm_alu_ex;
                ex_signal.alu_ops    = rv32i_types::add_alu_op;
                wb_signal.regf_m_sel = rv32i_types::alu_out_wb;
                wb_signal.regf_we    = 1'b1;
            end
            rv32i_types::imm_opcode: begin
                wb_signal.regf_we = 1'b1;
                case (i_if_id.funct3)
                    rv32i_types::slt_funct3, rv32i_types::sltu_funct3: begin
                        ex_signal.cmp_m_sel  = rv32i_types::i_imm_cmp_ex;
                        ex_signal.cmp_ops    = (i_if_id.funct3 == rv32i_types::slt_funct3)
                                             ? rv32i_types::blt_cmp_op
                                             : rv32i_types::bltu_cmp_op;
                        wb_signal.regf_m_sel = rv32i_types::br_en_wb;
                    end
                    rv32i_types::sr_funct3: begin
                        ex_signal.alu_m1_sel = rv32i_types::rs1_v_alu_ex;
                        ex_signal.alu_m2_sel = rv32i_types::i_imm_alu_ex;
                        ex_signal.alu_ops    = i_if_id.funct7[5] ? rv32i_types::sra_alu_op
                                                                 : rv32i_types::srl_alu_op;
                        wb_signal.regf_m_sel = rv32i_types::alu_out_wb;
                    end
                    default: begin  // addi has no sub form
                        ex_signal.alu_m1_sel = rv32i_types::rs1_v_alu_ex;
                        ex_signal.alu_m2_sel = rv32i_types::i_imm_alu_ex;
                        ex_signal.alu_ops    = rv32i_types::alu_op_t'(i_if_id.funct3);
                        wb_signal.regf_m_sel = rv32i_types::alu_out_wb;
                    end
                endcase
            end
            rv32i_types::reg_opcode: begin
                wb_signal.regf_we = 1'b1;
                case (i_if_id.funct3)
                    rv32i_types::slt_funct3, rv32i_types::sltu_funct3: begin
                        ex_signal.cmp_m_sel  = rv32i_types::rs2_v_cmp_ex;
                        ex_signal.cmp_ops    = (i_if_id.funct3 == rv32i_types::slt_funct3)
                                             ? rv32i_types::blt_cmp_op
                                             : rv32i_types::bltu_cmp_op;
                        wb_signal.regf_m_sel = rv32i_types::br_en_wb;
                    end
                    rv32i_types::sr_funct3: begin
                        ex_signal.alu_m1_sel = rv32i_types::rs1_v_alu_ex;
                        ex_signal.alu_m2_sel = rv32i_types::rs2_v_alu_ex;
                        ex_signal.alu_ops    = i_if_id.funct7[5] ? rv32i_types::sra_alu_op
                                                                 : rv32i_types::srl_alu_op;
                        wb_signal.regf_m_sel = rv32i_types::alu_out_wb;
                    end
                    rv32i_types::add_funct3: begin
                        ex_signal.alu_m1_sel = rv32i_types::rs1_v_alu_ex;
                        ex_signal.alu_m2_sel = rv32i_types::rs2_v_alu_ex;
                        ex_signal.alu_ops    = i_if_id.funct7[5] ? rv32i_types::sub_alu_op
                                                                 : rv32i_types::add_alu_op;
                        wb_signal.regf_m_sel = rv32i_types::alu_out_wb;
                    end
                    default: begin
                        ex_signal.alu_m1_sel = rv32i_types::rs1_v_alu_ex;
                        ex_signal.alu_m2_sel = rv32i_types::rs2_v_alu_ex;
                        ex_signal.alu_ops    = rv32i_types::alu_op_t'(i_if_id.funct3);
                        wb_signal.regf_m_sel = rv32i_types::alu_out_wb;
                    end
                endcase
            end
            default: begin
                // unsupported, retires without a write
            end
        endcase
    end

    always_comb begin
        o_id_ex.valid      = i_if_id.valid;
        o_id_ex.inst       = i_if_id.inst;
        o_id_ex.pc         = i_if_id.pc;
        o_id_ex.order      = i_if_id.order;
        o_id_ex.opcode     = i_if_id.opcode;
        o_id_ex.funct3     = i_if_id.funct3;
        o_id_ex.funct7     = i_if_id.funct7;
        o_id_ex.i_imm      = i_if_id.i_imm;
        o_id_ex.s_imm      = i_if_id.s_imm;
        o_id_ex.b_imm      = i_if_id.b_imm;
        o_id_ex.u_imm      = i_if_id.u_imm;
        o_id_ex.j_imm      = i_if_id.j_imm;
        o_id_ex.rs1_s      = i_if_id.rs1_s;
        o_id_ex.rs2_s      = i_if_id.rs2_s;
        o_id_ex.rd_s       = i_if_id.rd_s;
        o_id_ex.rs1_v      = rs1_v;
        o_id_ex.rs2_v      = rs2_v;
        o_id_ex.ex_signal  = ex_signal;
        o_id_ex.mem_signal = mem_signal;
        o_id_ex.wb_signal  = wb_signal;
    end

endmodule

//--- src/regfile.sv
module regfile (
    input  logic                     clk,
    input  logic                     i_reset,
    input  rv32i_types::regf_write_t i_write,
    input  rv32i_types::reg_sel_t    i_rs1_s,
    input  rv32i_types::reg_sel_t    i_rs2_s,
    output rv32i_types::word_t       o_rs1_v,
    output rv32i_types::word_t       o_rs2_v
);

    rv32i_types::word_t regs [rv32i_types::nregs];
    logic               wr_live;

    assign wr_live = i_write.we && (i_write.rd_s != '0);  // x0 never written

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < rv32i_types::nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_write.rd_s] <= i_write.rd_v;
        end
    end

    // write-through on a same-cycle hit
    assign o_rs1_v = (wr_live && i_write.rd_s == i_rs1_s) ? i_write.rd_v : regs[i_rs1_s];
    assign o_rs2_v = (wr_live && i_write.rd_s == i_rs2_s) ? i_write.rd_v : regs[i_rs2_s];

endmodule

//--- src/fetch_stage.sv
module fetch_stage (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic                          i_inst_valid,
    input  rv32i_types::word_t            i_inst,
    output rv32i_types::if_id_stage_reg_t o_if_id
);

    rv32i_types::word_t            pc;
    rv32i_types::order_t           order;
    rv32i_types::if_id_stage_reg_t if_id_next;

    // field slicing and immediates, done ahead of decode
    always_comb begin
        if_id_next.valid  = i_inst_valid;
        if_id_next.inst   = i_inst;
        if_id_next.pc     = pc;
        if_id_next.order  = order;
        if_id_next.opcode = rv32i_types::rv32i_opcode_t'(i_inst[6:0]);
        if_id_next.funct3 = rv32i_types::funct3_t'(i_inst[14:12]);
        if_id_next.funct7 = i_inst[31:25];
        if_id_next.rs1_s  = i_inst[19:15];
        if_id_next.rs2_s  = i_inst[24:20];
        if_id_next.rd_s   = i_inst[11:7];
        if_id_next.i_imm  = {{21{i_inst[31]}}, i_inst[30:20]};
        if_id_next.s_imm  = {{21{i_inst[31]}}, i_inst[30:25], i_inst[11:7]};
        if_id_next.b_imm  = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
        if_id_next.u_imm  = {i_inst[31:12], 12'h000};
        if_id_next.j_imm  = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc            <= rv32i_types::pc_reset;
            order         <= '0;
            o_if_id.valid <= 1'b0;
        end else begin
            o_if_id <= if_id_next;
            if (i_inst_valid) begin  // counters move per accepted inst
                pc    <= pc + rv32i_types::pc_step;
                order <= order + 64'd1;
            end
        end
    end

endmodule

//--- src/rv32i_types.sv
package rv32i_types;

    // ===================================================================
    // widths and constants
    // ===================================================================
    localparam int xlen  = 32;
    localparam int nregs = 32;

    typedef logic [xlen-1:0]          word_t;
    typedef logic [$clog2(nregs)-1:0] reg_sel_t;
    typedef logic [63:0]              order_t;

    localparam word_t pc_reset = '0;
    localparam word_t pc_step  = 32'd4;

    // ===================================================================
    // encodings
    // ===================================================================
    typedef enum logic [6:0] {
        lui_opcode   = 7'b0110111,
        auipc_opcode = 7'b0010111,
        imm_opcode   = 7'b0010011,
        reg_opcode   = 7'b0110011
    } rv32i_opcode_t;

    typedef enum logic [2:0] {
        add_funct3  = 3'b000,
        sll_funct3  = 3'b001,
        slt_funct3  = 3'b010,
        sltu_funct3 = 3'b011,
        xor_funct3  = 3'b100,
        sr_funct3   = 3'b101,
        or_funct3   = 3'b110,
        and_funct3  = 3'b111
    } funct3_t;

    // add/sll/xor/or/and line up with funct3
    typedef enum logic [2:0] {
        add_alu_op = 3'b000,
        sll_alu_op = 3'b001,
        sra_alu_op = 3'b010,
        sub_alu_op = 3'b011,
        xor_alu_op = 3'b100,
        srl_alu_op = 3'b101,
        or_alu_op  = 3'b110,
        and_alu_op = 3'b111
    } alu_op_t;

    typedef enum logic [2:0] {
        blt_cmp_op  = 3'b100,
        bltu_cmp_op = 3'b110
    } cmp_op_t;

    typedef enum logic {
        rs1_v_alu_ex  = 1'b0,
        pc_out_alu_ex = 1'b1
    } alu_m1_sel_t;

    typedef enum logic [1:0] {
        i_imm_alu_ex = 2'b00,
        u_imm_alu_ex = 2'b01,
        rs2_v_alu_ex = 2'b10
    } alu_m2_sel_t;

    typedef enum logic {
        i_imm_cmp_ex = 1'b0,
        rs2_v_cmp_ex = 1'b1
    } cmp_m_sel_t;

    typedef enum logic [1:0] {
        alu_out_wb = 2'b00,
        br_en_wb   = 2'b01,
        u_imm_wb   = 2'b10
    } regf_m_sel_t;

    // ===================================================================
    // control and stage registers
    // ===================================================================
    typedef struct packed {
        alu_m1_sel_t alu_m1_sel;
        alu_m2_sel_t alu_m2_sel;
        alu_op_t     alu_ops;
        cmp_m_sel_t  cmp_m_sel;
        cmp_op_t     cmp_ops;
    } ex_signal_t;

    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        logic [2:0] load_ops;
        logic [2:0] store_ops;
    } mem_signal_t;

    typedef struct packed {
        regf_m_sel_t regf_m_sel;
        logic        regf_we;
    } wb_signal_t;

    typedef struct packed {
        logic          valid;
        word_t         inst;
        word_t         pc;
        order_t        order;
        rv32i_opcode_t opcode;
        funct3_t       funct3;
        logic [6:0]    funct7;
        word_t         i_imm;
        word_t         s_imm;
        word_t         b_imm;
        word_t         u_imm;
        word_t         j_imm;
        reg_sel_t      rs1_s;
        reg_sel_t      rs2_s;
        reg_sel_t      rd_s;
    } if_id_stage_reg_t;

    typedef struct packed {
        logic          valid;
        word_t         inst;
        word_t         pc;
        order_t        order;
        rv32i_opcode_t opcode;
        funct3_t       funct3;
        logic [6:0]    funct7;
        word_t         i_imm;
        word_t         s_imm;
        word_t         b_imm;
        word_t         u_imm;
        word_t         j_imm;
        reg_sel_t      rs1_s;
        reg_sel_t      rs2_s;
        reg_sel_t      rd_s;
        word_t         rs1_v;
        word_t         rs2_v;
        ex_signal_t    ex_signal;
        mem_signal_t   mem_signal;
        wb_signal_t    wb_signal;
    } id_ex_stage_reg_t;

    typedef struct packed {
        logic       valid;
        word_t      inst;
        word_t      pc;
        order_t     order;
        reg_sel_t   rd_s;
        word_t      alu_out;
        logic       br_en;
        word_t      u_imm;
        wb_signal_t wb_signal;
    } ex_wb_stage_reg_t;

    typedef struct packed {
        logic     we;
        reg_sel_t rd_s;
        word_t    rd_v;
    } regf_write_t;

    typedef struct packed {
        logic     valid;
        order_t   order;
        word_t    pc;
        word_t    inst;
        reg_sel_t rd_s;
        word_t    rd_v;
        logic     we;
    } commit_t;

endpackage
